//--- design/decode_params.svh
// widths and fixed constants of the decode stage, included by every file that needs them
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// data and address width
`define XLEN 32

// register file address width
`define REG_ADDR_W 5

// link address is pc + 4
`define LINK_OFFSET 4

// LUI and AUIPC shift the upper immediate by this amount
`define UPPER_SHIFT 12

`endif

//--- design/decode_pkg.sv
// types shared by the decode stage modules: opcodes, operation codes, selects, instruction views
package decode_pkg;

    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'h03,
        OPCODE_OP_IMM = 7'h13,
        OPCODE_AUIPC  = 7'h17,
        OPCODE_STORE  = 7'h23,
        OPCODE_OP     = 7'h33,
        OPCODE_LUI    = 7'h37,
        OPCODE_BRANCH = 7'h63,
        OPCODE_JALR   = 7'h67,
        OPCODE_JAL    = 7'h6f
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    typedef enum logic [3:0] {
        JUMP_NONE, JUMP_BEQ, JUMP_BNE, JUMP_BLT, JUMP_BGE,
        JUMP_BLTU, JUMP_BGEU, JUMP_JAL, JUMP_JALR
    } jump_op_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {OPA_ZERO, OPA_RS1, OPA_PC, OPA_IMM} opnd_a_sel_e;

    typedef enum logic [2:0] {OPB_ZERO, OPB_RS2, OPB_IMM, OPB_LINK, OPB_SHIFT12} opnd_b_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one instruction word, read by field in the decoder and by immediate layout in imm_gen
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

//--- design/decode_stage.sv
// RV32I decode stage top, drives register file addresses and registers the decode into ID-EX
`include "decode_params.svh"

module decode_stage import decode_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    input  logic [`XLEN-1:0]        instr_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        rs1_rdata_i,
    input  logic [`XLEN-1:0]        rs2_rdata_i,
    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    output logic                    valid_o,
    output logic [`XLEN-1:0]        pc_o,
    output logic [`REG_ADDR_W-1:0]  rd_addr_o,
    output logic                    rd_we_o,
    output logic                    alu_sel_o,
    output alu_op_e                 alu_op_o,
    output logic [`XLEN-1:0]        alu_a_o,
    output logic [`XLEN-1:0]        alu_b_o,
    output logic                    lsu_req_o,
    output logic                    lsu_we_o,
    output lsu_op_e                 lsu_op_o,
    output logic                    cond_jump_o,
    output jump_op_e                jump_op_o,
    output logic [`XLEN-1:0]        jump_imm_o
);

    instr_u           instr;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] opnd_a;
    logic [`XLEN-1:0] opnd_b;

    id_ctrl_if ctrl_if ();

    assign instr      = instr_i;
    assign rs1_addr_o = instr.r.rs1; // register file read, same cycle
    assign rs2_addr_o = instr.r.rs2;

    op_decoder op_decoder_i (
        .instr_i (instr),
        .ctrl    (ctrl_if.dec)
    );

    imm_gen imm_gen_i (
        .instr_i (instr),
        .ctrl    (ctrl_if.imm),
        .imm_o   (imm)
    );

    operand_mux operand_mux_i (
        .ctrl        (ctrl_if.mux),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .pc_i        (pc_i),
        .imm_i       (imm),
        .opnd_a_o    (opnd_a),
        .opnd_b_o    (opnd_b)
    );

    id_ex_reg id_ex_reg_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid_i),
        .ctrl        (ctrl_if.pipe),
        .pc_i        (pc_i),
        .rd_addr_i   (instr.r.rd),
        .opnd_a_i    (opnd_a),
        .opnd_b_i    (opnd_b),
        .imm_i       (imm),
        .valid_o     (valid_o),
        .pc_o        (pc_o),
        .rd_addr_o   (rd_addr_o),
        .rd_we_o     (rd_we_o),
        .alu_sel_o   (alu_sel_o),
        .alu_op_o    (alu_op_o),
        .alu_a_o     (alu_a_o),
        .alu_b_o     (alu_b_o),
        .lsu_req_o   (lsu_req_o),
        .lsu_we_o    (lsu_we_o),
        .lsu_op_o    (lsu_op_o),
        .cond_jump_o (cond_jump_o),
        .jump_op_o   (jump_op_o),
        .jump_imm_o  (jump_imm_o)
    );

endmodule

//--- design/id_ctrl_if.sv
// decoded control bundle, driven by op_decoder and read by imm_gen, operand_mux and id_ex_reg
interface id_ctrl_if import decode_pkg::*; ();

    logic        alu_sel;
    alu_op_e     alu_op;
    logic        lsu_req;
    logic        lsu_we;
    lsu_op_e     lsu_op;
    logic        cond_jump;
    jump_op_e    jump_op;
    logic        rd_we;
    imm_sel_e    imm_sel;
    opnd_a_sel_e a_sel;
    opnd_b_sel_e b_sel;

    modport dec (
        output alu_sel, alu_op, lsu_req, lsu_we, lsu_op,
        output cond_jump, jump_op, rd_we, imm_sel, a_sel, b_sel
    );

    modport imm (input imm_sel);

    modport mux (input a_sel, b_sel);

    modport pipe (
        input alu_sel, alu_op, lsu_req, lsu_we, lsu_op, cond_jump, jump_op, rd_we
    );

endinterface

//--- design/id_ex_reg.sv
// ID-EX pipeline register, loads a bubble on reset or when no valid instruction is presented
`include "decode_params.svh"

module id_ex_reg import decode_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    id_ctrl_if.pipe                 ctrl,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [`XLEN-1:0]        opnd_a_i,
    input  logic [`XLEN-1:0]        opnd_b_i,
    input  logic [`XLEN-1:0]        imm_i,
    output logic                    valid_o,
    output logic [`XLEN-1:0]        pc_o,
    output logic [`REG_ADDR_W-1:0]  rd_addr_o,
    output logic                    rd_we_o,
    output logic                    alu_sel_o,
    output alu_op_e                 alu_op_o,
    output logic [`XLEN-1:0]        alu_a_o,
    output logic [`XLEN-1:0]        alu_b_o,
    output logic                    lsu_req_o,
    output logic                    lsu_we_o,
    output lsu_op_e                 lsu_op_o,
    output logic                    cond_jump_o,
    output jump_op_e                jump_op_o,
    output logic [`XLEN-1:0]        jump_imm_o
);

    logic uncond_jump;

    assign uncond_jump = (ctrl.jump_op == JUMP_JAL) || (ctrl.jump_op == JUMP_JALR);

    always_ff @(posedge clk_i) begin
        if (!rst_ni || !valid_i) begin
            valid_o     <= 1'b0;
            pc_o        <= '0;
            rd_addr_o   <= '0;
            rd_we_o     <= 1'b0;
            alu_sel_o   <= 1'b0;
            alu_op_o    <= ALU_NONE;
            alu_a_o     <= '0;
            alu_b_o     <= '0;
            lsu_req_o   <= 1'b0;
            lsu_we_o    <= 1'b0;
            lsu_op_o    <= LSU_NONE;
            cond_jump_o <= 1'b0;
            jump_op_o   <= JUMP_NONE;
            jump_imm_o  <= '0;
        end else begin
            valid_o     <= 1'b1;
            pc_o        <= pc_i;
            rd_addr_o   <= rd_addr_i;
            rd_we_o     <= ctrl.rd_we;
            alu_sel_o   <= ctrl.alu_sel;
            alu_op_o    <= ctrl.alu_op;
            alu_a_o     <= opnd_a_i;
            alu_b_o     <= opnd_b_i;
            lsu_req_o   <= ctrl.lsu_req;
            lsu_we_o    <= ctrl.lsu_we;
            lsu_op_o    <= ctrl.lsu_op;
            cond_jump_o <= ctrl.cond_jump;
            jump_op_o   <= ctrl.jump_op;
            jump_imm_o  <= uncond_jump ? imm_i : '0; // branch offset goes via alu_b
        end
    end

endmodule

//--- design/imm_gen.sv
// builds the sign-extended immediate of the format chosen by the decoder, combinational
`include "decode_params.svh"

module imm_gen import decode_pkg::*; (
    input  instr_u                  instr_i,
    id_ctrl_if.imm                  ctrl,
    output logic [`XLEN-1:0]        imm_o
);

    always_comb begin
        unique case (ctrl.imm_sel)
            IMM_I: imm_o = {{(`XLEN-12){instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
            IMM_S: begin
                imm_o = {{(`XLEN-12){instr_i.s.imm11_5[6]}},
                         instr_i.s.imm11_5,
                         instr_i.s.imm4_0};
            end
            IMM_B: begin // bit 0 always zero
                imm_o = {{(`XLEN-13){instr_i.b.imm12}},
                         instr_i.b.imm12,
                         instr_i.b.imm11,
                         instr_i.b.imm10_5,
                         instr_i.b.imm4_1,
                         1'b0};
            end
            IMM_U: imm_o = {{(`XLEN-20){instr_i.u.imm31_12[19]}}, instr_i.u.imm31_12};
            IMM_J: begin
                imm_o = {{(`XLEN-21){instr_i.j.imm20}},
                         instr_i.j.imm20,
                         instr_i.j.imm19_12,
                         instr_i.j.imm11,
                         instr_i.j.imm10_1,
                         1'b0};
            end
            default: imm_o = '0; // no immediate
        endcase
    end

endmodule

//--- design/op_decoder.sv
// opcode and funct decode of one RV32I instruction into the control bundle, combinational
module op_decoder import decode_pkg::*; (
    input  instr_u instr_i,
    id_ctrl_if.dec ctrl
);

    opcode_e opcode;
    logic    legal;

    assign opcode = opcode_e'(instr_i.r.opcode);

    always_comb begin
        ctrl.alu_sel   = 1'b0;
        ctrl.alu_op    = ALU_NONE;
        ctrl.lsu_req   = 1'b0;
        ctrl.lsu_we    = 1'b0;
        ctrl.lsu_op    = LSU_NONE;
        ctrl.cond_jump = 1'b0;
        ctrl.jump_op   = JUMP_NONE;
        ctrl.rd_we     = 1'b0;
        ctrl.imm_sel   = IMM_NONE;
        ctrl.a_sel     = OPA_ZERO;
        ctrl.b_sel     = OPB_ZERO;
        legal          = 1'b1;
        unique case (opcode)
            OPCODE_OP: begin
                ctrl.a_sel   = OPA_RS1;
                ctrl.b_sel   = OPB_RS2;
                ctrl.rd_we   = 1'b1;
                ctrl.alu_sel = 1'b1;
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {7'h00, 3'h0}: ctrl.alu_op = ALU_ADD;
                    {7'h20, 3'h0}: ctrl.alu_op = ALU_SUB;
                    {7'h00, 3'h4}: ctrl.alu_op = ALU_XOR;
                    {7'h00, 3'h6}: ctrl.alu_op = ALU_OR;
                    {7'h00, 3'h7}: ctrl.alu_op = ALU_AND;
                    {7'h00, 3'h1}: ctrl.alu_op = ALU_SLL;
                    {7'h00, 3'h5}: ctrl.alu_op = ALU_SRL;
                    {7'h20, 3'h5}: ctrl.alu_op = ALU_SRA;
                    {7'h00, 3'h2}: ctrl.alu_op = ALU_SLT;
                    {7'h00, 3'h3}: ctrl.alu_op = ALU_SLTU;
                    default:       legal = 1'b0; // incl. the M extension
                endcase
            end
            OPCODE_OP_IMM: begin
                ctrl.imm_sel = IMM_I;
                ctrl.a_sel   = OPA_RS1;
                ctrl.b_sel   = OPB_IMM;
                ctrl.rd_we   = 1'b1;
                ctrl.alu_sel = 1'b1;
                case (instr_i.i.funct3)
                    3'b000: ctrl.alu_op = ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    3'b001: begin
                        if (instr_i.r.funct7 == 7'h00) ctrl.alu_op = ALU_SLL;
                        else legal = 1'b0;
                    end
                    default: begin // funct3 101, shift right
                        if (instr_i.r.funct7 == 7'h00) ctrl.alu_op = ALU_SRL;
                        else if (instr_i.r.funct7 == 7'h20) ctrl.alu_op = ALU_SRA;
                        else legal = 1'b0;
                    end
                endcase
            end
            OPCODE_LOAD: begin
                ctrl.imm_sel = IMM_I;
                ctrl.a_sel   = OPA_RS1;
                ctrl.b_sel   = OPB_IMM;
                ctrl.rd_we   = 1'b1;
                ctrl.lsu_req = 1'b1;
                case (instr_i.i.funct3)
                    3'b000:  ctrl.lsu_op = LSU_LB;
                    3'b001:  ctrl.lsu_op = LSU_LH;
                    3'b010:  ctrl.lsu_op = LSU_LW;
                    3'b100:  ctrl.lsu_op = LSU_LBU;
                    3'b101:  ctrl.lsu_op = LSU_LHU;
                    default: legal = 1'b0;
                endcase
            end
            OPCODE_STORE: begin
                ctrl.imm_sel = IMM_S;
                ctrl.a_sel   = OPA_RS1;
                ctrl.b_sel   = OPB_IMM;
                ctrl.lsu_req = 1'b1;
                ctrl.lsu_we  = 1'b1;
                case (instr_i.s.funct3)
                    3'b000:  ctrl.lsu_op = LSU_SB;
                    3'b001:  ctrl.lsu_op = LSU_SH;
                    3'b010:  ctrl.lsu_op = LSU_SW;
                    default: legal = 1'b0;
                endcase
            end
            OPCODE_BRANCH: begin
                ctrl.imm_sel   = IMM_B;
                ctrl.a_sel     = OPA_PC; // branch target pc + imm
                ctrl.b_sel     = OPB_IMM;
                ctrl.cond_jump = 1'b1;
                case (instr_i.b.funct3)
                    3'b000:  ctrl.jump_op = JUMP_BEQ;
                    3'b001:  ctrl.jump_op = JUMP_BNE;
                    3'b100:  ctrl.jump_op = JUMP_BLT;
                    3'b101:  ctrl.jump_op = JUMP_BGE;
                    3'b110:  ctrl.jump_op = JUMP_BLTU;
                    3'b111:  ctrl.jump_op = JUMP_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPCODE_JAL, OPCODE_JALR: begin
                ctrl.imm_sel = (opcode == OPCODE_JAL) ? IMM_J : IMM_I;
                ctrl.a_sel   = OPA_PC;
                ctrl.b_sel   = OPB_LINK; // link address
                ctrl.rd_we   = 1'b1;
                ctrl.alu_sel = 1'b1;
                ctrl.alu_op  = ALU_ADD;
                ctrl.jump_op = (opcode == OPCODE_JAL) ? JUMP_JAL : JUMP_JALR;
                if (opcode == OPCODE_JALR && instr_i.i.funct3 != 3'b000) legal = 1'b0;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                ctrl.imm_sel = IMM_U;
                ctrl.a_sel   = OPA_IMM;
                ctrl.b_sel   = OPB_SHIFT12;
                ctrl.rd_we   = 1'b1;
                ctrl.alu_sel = 1'b1;
                ctrl.alu_op  = (opcode == OPCODE_LUI) ? ALU_SLL : ALU_AUIPC;
            end
            default: legal = 1'b0;
        endcase

        // anything not decoded above leaves as a bubble
        if (!legal) begin
            ctrl.alu_sel   = 1'b0;
            ctrl.alu_op    = ALU_NONE;
            ctrl.lsu_req   = 1'b0;
            ctrl.lsu_we    = 1'b0;
            ctrl.lsu_op    = LSU_NONE;
            ctrl.cond_jump = 1'b0;
            ctrl.jump_op   = JUMP_NONE;
            ctrl.rd_we     = 1'b0;
            ctrl.imm_sel   = IMM_NONE;
            ctrl.a_sel     = OPA_ZERO;
            ctrl.b_sel     = OPB_ZERO;
        end
    end

endmodule

//--- design/operand_mux.sv
// selects ALU operands A and B from register data, pc, immediate and constants
`include "decode_params.svh"

module operand_mux import decode_pkg::*; (
    id_ctrl_if.mux                  ctrl,
    input  logic [`XLEN-1:0]        rs1_rdata_i,
    input  logic [`XLEN-1:0]        rs2_rdata_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        imm_i,
    output logic [`XLEN-1:0]        opnd_a_o,
    output logic [`XLEN-1:0]        opnd_b_o
);

    always_comb begin
        unique case (ctrl.a_sel)
            OPA_RS1: opnd_a_o = rs1_rdata_i;
            OPA_PC:  opnd_a_o = pc_i;
            OPA_IMM: opnd_a_o = imm_i;        // upper immediate for LUI/AUIPC
            default: opnd_a_o = '0;
        endcase
    end

    always_comb begin
        unique case (ctrl.b_sel)
            OPB_RS2:     opnd_b_o = rs2_rdata_i;
            OPB_IMM:     opnd_b_o = imm_i;
            OPB_LINK:    opnd_b_o = `XLEN'(`LINK_OFFSET);
            OPB_SHIFT12: opnd_b_o = `XLEN'(`UPPER_SHIFT); // shift amount in the ALU
            default:     opnd_b_o = '0;
        endcase
    end

endmodule

//--- tb.f
+incdir+design
+incdir+testbench
design/decode_pkg.sv
design/id_ctrl_if.sv
design/op_decoder.sv
design/imm_gen.sv
design/operand_mux.sv
design/id_ex_reg.sv
design/decode_stage.sv
testbench/tb_decode_stage.sv

//--- testbench/decode_model.svh
// reference model of the decode stage, gives the expected ID-EX contents for one input cycle
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic                   rd_we;
    logic                   alu_sel;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       alu_a;
    logic [`XLEN-1:0]       alu_b;
    logic                   lsu_req;
    logic                   lsu_we;
    lsu_op_e                lsu_op;
    logic                   cond_jump;
    jump_op_e               jump_op;
    logic [`XLEN-1:0]       jump_imm;
} id_ex_t;

// bubble contents of the register
function automatic id_ex_t idle_state();
    id_ex_t s;
    s.valid     = 1'b0;
    s.pc        = '0;
    s.rd_addr   = '0;
    s.rd_we     = 1'b0;
    s.alu_sel   = 1'b0;
    s.alu_op    = ALU_NONE;
    s.alu_a     = '0;
    s.alu_b     = '0;
    s.lsu_req   = 1'b0;
    s.lsu_we    = 1'b0;
    s.lsu_op    = LSU_NONE;
    s.cond_jump = 1'b0;
    s.jump_op   = JUMP_NONE;
    s.jump_imm  = '0;
    return s;
endfunction

// funct3 map shared by OP and OP-IMM, alt picks SUB or SRA
function automatic alu_op_e alu_for(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic id_ex_t decode_model(input logic valid, input logic [`XLEN-1:0] instr,
        input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] rs1, input logic [`XLEN-1:0] rs2);
    id_ex_t           r;
    id_ex_t           e;
    logic [6:0]       f7;
    logic [2:0]       f3;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             ok;
    r = idle_state();
    if (!valid) return r;
    r.valid   = 1'b1;
    r.pc      = pc;
    r.rd_addr = instr[11:7]; // passed on even for a bubble decode
    e  = r;
    f7 = instr[31:25];
    f3 = instr[14:12];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {{12{instr[31]}}, instr[31:12]}; // shifted later in the ALU
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    ok = 1'b1;
    case (instr[6:0])
        7'h33: begin
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            e.alu_sel = 1'b1;
            e.rd_we   = 1'b1;
            e.alu_op  = alu_for(f3, f7[5]);
            e.alu_a   = rs1;
            e.alu_b   = rs2;
        end
        7'h13: begin
            ok = !(f3 == 3'd1 && f7 != 7'h00) &&
                 !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            e.alu_sel = 1'b1;
            e.rd_we   = 1'b1;
            e.alu_op  = alu_for(f3, f3 == 3'd5 && f7[5]); // no SUBI
            e.alu_a   = rs1;
            e.alu_b   = imm_i;
        end
        7'h03: begin
            ok = (f3 != 3'd3) && (f3 < 3'd6);
            e.lsu_req = 1'b1;
            e.rd_we   = 1'b1;
            e.lsu_op  = f3 == 3'd0 ? LSU_LB : f3 == 3'd1 ? LSU_LH : f3 == 3'd2 ? LSU_LW :
                        f3 == 3'd4 ? LSU_LBU : LSU_LHU;
            e.alu_a   = rs1;
            e.alu_b   = imm_i;
        end
        7'h23: begin
            ok = f3 < 3'd3;
            e.lsu_req = 1'b1;
            e.lsu_we  = 1'b1;
            e.lsu_op  = f3 == 3'd0 ? LSU_SB : f3 == 3'd1 ? LSU_SH : LSU_SW;
            e.alu_a   = rs1;
            e.alu_b   = imm_s;
        end
        7'h63: begin
            ok = (f3 != 3'd2) && (f3 != 3'd3);
            e.cond_jump = 1'b1;
            e.jump_op   = f3 == 3'd0 ? JUMP_BEQ : f3 == 3'd1 ? JUMP_BNE :
                          f3 == 3'd4 ? JUMP_BLT : f3 == 3'd5 ? JUMP_BGE :
                          f3 == 3'd6 ? JUMP_BLTU : JUMP_BGEU;
            e.alu_a     = pc;
            e.alu_b     = imm_b;
        end
        7'h6f, 7'h67: begin
            ok = (instr[6:0] == 7'h6f) || (f3 == 3'd0);
            e.alu_sel  = 1'b1;
            e.rd_we    = 1'b1;
            e.alu_op   = ALU_ADD; // link = pc + 4
            e.alu_a    = pc;
            e.alu_b    = `XLEN'(`LINK_OFFSET);
            e.jump_op  = (instr[6:0] == 7'h6f) ? JUMP_JAL : JUMP_JALR;
            e.jump_imm = (instr[6:0] == 7'h6f) ? imm_j : imm_i;
        end
        7'h37, 7'h17: begin
            e.alu_sel = 1'b1;
            e.rd_we   = 1'b1;
            e.alu_op  = (instr[6:0] == 7'h37) ? ALU_SLL : ALU_AUIPC;
            e.alu_a   = imm_u;
            e.alu_b   = `XLEN'(`UPPER_SHIFT);
        end
        default: ok = 1'b0;
    endcase
    if (ok)
        return e;
    else
        return r;
endfunction

`endif

//--- testbench/tb_decode_stage.sv
// self-checking testbench for decode_stage, random instructions compared against decode_model
`include "decode_params.svh"

module tb_decode_stage import decode_pkg::*; ();

`include "decode_model.svh"

    localparam int NUM_INSTR     = 2000;
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 64;
    localparam int RUN_TIMEOUT   = 20000;
    localparam int DRAIN_TIMEOUT = 16;

    logic clk = 1'b0;
    logic                   rst_ni;
    logic                   valid_i;
    logic [`XLEN-1:0]       instr_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`XLEN-1:0]       rs1_rdata_i;
    logic [`XLEN-1:0]       rs2_rdata_i;
    logic [`REG_ADDR_W-1:0] rs1_addr_o;
    logic [`REG_ADDR_W-1:0] rs2_addr_o;
    logic                   valid_o;
    logic [`XLEN-1:0]       pc_o;
    logic [`REG_ADDR_W-1:0] rd_addr_o;
    logic                   rd_we_o;
    logic                   alu_sel_o;
    alu_op_e                alu_op_o;
    logic [`XLEN-1:0]       alu_a_o;
    logic [`XLEN-1:0]       alu_b_o;
    logic                   lsu_req_o;
    logic                   lsu_we_o;
    lsu_op_e                lsu_op_o;
    logic                   cond_jump_o;
    jump_op_e               jump_op_o;
    logic [`XLEN-1:0]       jump_imm_o;

    integer seed;
    int     checked;
    id_ex_t exp_next; // from the inputs presented this cycle
    id_ex_t exp_q;    // what the ID-EX register holds now

    decode_stage decode_stage_i (
        .clk_i       (clk),
        .rst_ni      (rst_ni),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .valid_o     (valid_o),
        .pc_o        (pc_o),
        .rd_addr_o   (rd_addr_o),
        .rd_we_o     (rd_we_o),
        .alu_sel_o   (alu_sel_o),
        .alu_op_o    (alu_op_o),
        .alu_a_o     (alu_a_o),
        .alu_b_o     (alu_b_o),
        .lsu_req_o   (lsu_req_o),
        .lsu_we_o    (lsu_we_o),
        .lsu_op_o    (lsu_op_o),
        .cond_jump_o (cond_jump_o),
        .jump_op_o   (jump_op_o),
        .jump_imm_o  (jump_imm_o)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
            input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            abort_run("output differs from the reference model");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
            abort_run("output differs from the reference model");
        end
    endtask

    task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=%s expected=%s actual=%s(%h)",
                     $time, name, exp.name(), act.name(), act);
            abort_run("output differs from the reference model");
        end
    endtask

    task automatic check_lsu(input string name, input lsu_op_e exp, input lsu_op_e act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=%s expected=%s actual=%s(%h)",
                     $time, name, exp.name(), act.name(), act);
            abort_run("output differs from the reference model");
        end
    endtask

    task automatic check_jump(input string name, input jump_op_e exp, input jump_op_e act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=%s expected=%s actual=%s(%h)",
                     $time, name, exp.name(), act.name(), act);
            abort_run("output differs from the reference model");
        end
    endtask

    // register file addresses are checked against the word presented now
    task automatic compare_outputs();
        check_word("rs1_addr_o", `XLEN'(instr_i[19:15]), `XLEN'(rs1_addr_o));
        check_word("rs2_addr_o", `XLEN'(instr_i[24:20]), `XLEN'(rs2_addr_o));
        check_bit("valid_o", exp_q.valid, valid_o);
        check_word("pc_o", exp_q.pc, pc_o);
        check_word("rd_addr_o", `XLEN'(exp_q.rd_addr), `XLEN'(rd_addr_o));
        check_bit("rd_we_o", exp_q.rd_we, rd_we_o);
        check_bit("alu_sel_o", exp_q.alu_sel, alu_sel_o);
        check_alu("alu_op_o", exp_q.alu_op, alu_op_o);
        check_word("alu_a_o", exp_q.alu_a, alu_a_o);
        check_word("alu_b_o", exp_q.alu_b, alu_b_o);
        check_bit("lsu_req_o", exp_q.lsu_req, lsu_req_o);
        check_bit("lsu_we_o", exp_q.lsu_we, lsu_we_o);
        check_lsu("lsu_op_o", exp_q.lsu_op, lsu_op_o);
        check_bit("cond_jump_o", exp_q.cond_jump, cond_jump_o);
        check_jump("jump_op_o", exp_q.jump_op, jump_op_o);
        check_word("jump_imm_o", exp_q.jump_imm, jump_imm_o);
        if (exp_q.valid) checked++;
    endtask

    // about 80% legal encodings, the rest raw words or kept opcodes with bad funct
    function automatic logic [`XLEN-1:0] rand_instr();
        logic [`XLEN-1:0] w;
        int               kind;
        logic [2:0]       f3;
        w    = $random(seed);
        kind = {$random(seed)} % 100;
        f3   = w[14:12];
        if (kind < 10) return w;
        if (kind < 20) begin
            case (kind % 4)
                0: return {7'h01, w[24:15], f3, w[11:7], 7'h33};            // M extension
                1: return {w[31:15], f3[2] ? {2'b11, f3[0]} : 3'b011, w[11:7], 7'h03};
                2: return {w[31:15], (f3 == 3'd0) ? 3'd1 : f3, w[11:7], 7'h67};
                default: return {w[31:15], 2'b01, f3[0], w[11:7], 7'h63};
            endcase
        end
        case (kind % 9)
            0: return {((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00,
                       w[24:15], f3, w[11:7], 7'h33};
            1: begin
                if (f3 == 3'd1) w[31:25] = 7'h00;
                if (f3 == 3'd5) w[31:25] = w[30] ? 7'h20 : 7'h00; // SRAI or SRLI
                return {w[31:7], 7'h13};
            end
            2: return {w[31:15], (f3 == 3'd3) ? 3'd2 : (f3 > 3'd5) ? f3 - 3'd2 : f3,
                       w[11:7], 7'h03};
            3: return {w[31:15], 3'(f3 % 3), w[11:7], 7'h23};
            4: return {w[31:15], (f3[2:1] == 2'b01) ? (f3 | 3'b100) : f3, w[11:7], 7'h63};
            5: return {w[31:7], 7'h6f};
            6: return {w[31:15], 3'b000, w[11:7], 7'h67};
            7: return {w[31:7], 7'h37};
            default: return {w[31:7], 7'h17};
        endcase
    endfunction

    task automatic drive_cycle(input logic rst, input logic valid, input logic [`XLEN-1:0] instr);
        @(posedge clk);
        #1;
        exp_q       = exp_next; // the edge just captured these inputs
        rst_ni      = rst;
        valid_i     = valid;
        instr_i     = instr;
        pc_i        = $random(seed) & ~32'h3;
        rs1_rdata_i = $random(seed);
        rs2_rdata_i = $random(seed);
        exp_next    = decode_model(rst && valid, instr_i, pc_i, rs1_rdata_i, rs2_rdata_i);
    endtask

    initial begin : stim_proc
        int   issued;
        int   cyc;
        logic v;
        seed        = 80;
        issued      = 0;
        cyc         = 0;
        checked     = 0;
        rst_ni      = 1'b0;
        valid_i     = 1'b0;
        instr_i     = '0;
        pc_i        = '0;
        rs1_rdata_i = '0;
        rs2_rdata_i = '0;
        exp_q       = idle_state();
        exp_next    = idle_state();
        // first edge is already in reset, valid high must still give bubbles
        repeat (RESET_CYCLES - 1) drive_cycle(1'b0, 1'b1, rand_instr());
        drive_cycle(1'b1, 1'b0, rand_instr());
        while (issued < NUM_INSTR) begin
            if (cyc == RUN_TIMEOUT) abort_run("stimulus did not issue all instructions in time");
            v = ({$random(seed)} % 4) != 0;
            drive_cycle(1'b1, v, rand_instr());
            if (v) issued++;
            cyc++;
        end
        cyc = 0;
        while (checked < NUM_INSTR) begin
            if (cyc == DRAIN_TIMEOUT) abort_run("last instructions never left the ID-EX register");
            drive_cycle(1'b1, 1'b0, rand_instr());
            cyc++;
        end
        $display("Testbench passed");
        $finish;
    end

    initial begin : check_proc
        int cyc;
        cyc = 0;
        while (rst_ni !== 1'b1) begin // outputs idle all through reset
            if (cyc == RESET_TIMEOUT) abort_run("reset was not released in time");
            @(negedge clk);
            compare_outputs();
            cyc++;
        end
        forever begin
            @(negedge clk);
            compare_outputs();
        end
    end

endmodule
